// File: rtl/decodePkg.sv
`default_nettype none

package decodePkg;

    // Widths fixed by the 32-bit ISA
    typedef logic [31:0] instrT;
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;

    // RV32I major opcodes
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opReg    = 7'b0110011;
    localparam opcodeT opSystem = 7'b1110011;

    // ALU operation codes as seen by the execute stage
    typedef logic [4:0] aluCtrlT;

    localparam aluCtrlT aluAnd    = 5'd0;
    localparam aluCtrlT aluOr     = 5'd1;
    localparam aluCtrlT aluAdd    = 5'd2;
    localparam aluCtrlT aluXor    = 5'd3;
    localparam aluCtrlT aluSub    = 5'd4;
    localparam aluCtrlT aluSll    = 5'd6;
    localparam aluCtrlT aluSrl    = 5'd7;
    localparam aluCtrlT aluSra    = 5'd8;
    localparam aluCtrlT aluSlt    = 5'd9;
    localparam aluCtrlT aluSltu   = 5'd10;
    localparam aluCtrlT aluMul    = 5'd11;
    localparam aluCtrlT aluMulh   = 5'd12;
    localparam aluCtrlT aluMulhsu = 5'd13;
    localparam aluCtrlT aluMulhu  = 5'd14;
    localparam aluCtrlT aluDiv    = 5'd15;
    localparam aluCtrlT aluDivu   = 5'd16;
    localparam aluCtrlT aluRem    = 5'd17;
    localparam aluCtrlT aluRemu   = 5'd18;

    // Immediate layouts
    typedef logic [2:0] immFmtT;

    localparam immFmtT immNone = 3'd0;
    localparam immFmtT immI    = 3'd1;
    localparam immFmtT immS    = 3'd2;
    localparam immFmtT immB    = 3'd3;
    localparam immFmtT immU    = 3'd4;
    localparam immFmtT immJ    = 3'd5;

    // How the ALU code is chosen; modeAdd doubles as the idle value
    typedef logic [1:0] aluModeT;

    localparam aluModeT modeAdd = 2'd0;
    localparam aluModeT modeSub = 2'd1;
    localparam aluModeT modeReg = 2'd2;
    localparam aluModeT modeImm = 2'd3;

endpackage

`default_nettype wire

// File: rtl/decodeRegs.sv
`timescale 1ns/1ps
`default_nettype none

module decodeRegs (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            instValid,
    input  wire decodePkg::instrT instruction,
    input  wire decodePkg::wordT regValue1,
    input  wire decodePkg::wordT regValue2,
    output logic                 validQ,
    output decodePkg::instrT     instrQ,
    output decodePkg::wordT      value1,
    output decodePkg::wordT      value2
);

    // One stage of pipeline state, loaded every cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            validQ <= 1'b0;
            instrQ <= '0;
            value1 <= '0;
            value2 <= '0;
        end
        else
        begin
            validQ <= instValid;
            instrQ <= instruction;
            value1 <= regValue1;
            value2 <= regValue2;
        end
    end

endmodule

`default_nettype wire

// File: rtl/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  wire decodePkg::instrT  instrQ,
    input  wire decodePkg::immFmtT immFmt,
    output decodePkg::wordT        imm
);

    logic signBit;

    assign signBit = instrQ[31];

    always_comb
    begin
        case (immFmt)
            decodePkg::immI:
                imm = {{20{signBit}}, instrQ[31:20]};
            decodePkg::immS:
                imm = {{20{signBit}}, instrQ[31:25], instrQ[11:7]};
            // Branch offset, halfword aligned
            decodePkg::immB:
                imm = {{19{signBit}}, signBit, instrQ[7], instrQ[30:25],
                       instrQ[11:8], 1'b0};
            decodePkg::immU:
                imm = {instrQ[31:12], 12'b0};
            decodePkg::immJ:
                imm = {{11{signBit}}, signBit, instrQ[19:12], instrQ[20],
                       instrQ[30:21], 1'b0};
            // immNone and unused codes
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/aluControlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module aluControlDecode (
    input  wire decodePkg::aluModeT aluMode,
    input  wire logic [2:0]         func3,
    input  wire logic [6:0]         func7,
    output decodePkg::aluCtrlT      aluControl,
    output logic                    functBad
);

    // Base integer ops shared by OP and OP-IMM
    function automatic decodePkg::aluCtrlT baseOp(input logic [2:0] f3);
        decodePkg::aluCtrlT op;
        case (f3)
            3'b000:  op = decodePkg::aluAdd;
            3'b001:  op = decodePkg::aluSll;
            3'b010:  op = decodePkg::aluSlt;
            3'b011:  op = decodePkg::aluSltu;
            3'b100:  op = decodePkg::aluXor;
            3'b101:  op = decodePkg::aluSrl;
            3'b110:  op = decodePkg::aluOr;
            default: op = decodePkg::aluAnd;
        endcase
        return op;
    endfunction

    always_comb
    begin
        aluControl = decodePkg::aluAdd;
        functBad   = 1'b0;
        case (aluMode)
            decodePkg::modeSub:
                aluControl = decodePkg::aluSub;
            decodePkg::modeReg:
            begin
                if (func7 == 7'h00)
                    aluControl = baseOp(func3);
                else if (func7 == 7'h20 && func3 == 3'b000)
                    aluControl = decodePkg::aluSub;
                else if (func7 == 7'h20 && func3 == 3'b101)
                    aluControl = decodePkg::aluSra;
                // RV32M codes are contiguous from MUL
                else if (func7 == 7'h01)
                    aluControl = decodePkg::aluMul + decodePkg::aluCtrlT'(func3);
                else
                    functBad = 1'b1;
            end
            decodePkg::modeImm:
            begin
                // Shift amount sits in rs2, upper bits act as func7
                if (func3 == 3'b001 && func7 != 7'h00)
                    functBad = 1'b1;
                else if (func3 == 3'b101 && func7 == 7'h20)
                    aluControl = decodePkg::aluSra;
                else if (func3 == 3'b101 && func7 != 7'h00)
                    functBad = 1'b1;
                else
                    aluControl = baseOp(func3);
            end
            default:
                aluControl = decodePkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/controlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
    input  wire logic              validQ,
    input  wire decodePkg::opcodeT opcode,
    input  wire logic [2:0]        func3,
    input  wire logic              functBad,
    output logic                   regWrite,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   memToReg,
    output logic                   aluSrc,
    output logic                   pcSrc,
    output decodePkg::immFmtT      immFmt,
    output decodePkg::aluModeT     aluMode,
    output logic [2:0]             branchType,
    output logic                   illegal
);

    logic instrBad;

    // Mode depends on opcode only, so functBad never feeds back into it
    always_comb
    begin
        aluMode = decodePkg::modeAdd;
        if (validQ)
        begin
            case (opcode)
                decodePkg::opBranch: aluMode = decodePkg::modeSub;
                decodePkg::opImm:    aluMode = decodePkg::modeImm;
                decodePkg::opReg:    aluMode = decodePkg::modeReg;
                default:             aluMode = decodePkg::modeAdd;
            endcase
        end
    end

    always_comb
    begin
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        aluSrc     = 1'b0;
        pcSrc      = 1'b0;
        immFmt     = decodePkg::immNone;
        branchType = 3'b000;
        instrBad   = 1'b0;
        if (validQ)
        begin
            case (opcode)
                decodePkg::opLui, decodePkg::opAuipc:
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immFmt   = decodePkg::immU;
                end
                decodePkg::opJal, decodePkg::opJalr:
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    pcSrc    = 1'b1;
                    immFmt   = (opcode == decodePkg::opJal) ? decodePkg::immJ : decodePkg::immI;
                    instrBad = (opcode == decodePkg::opJalr) && (func3 != 3'b000);
                end
                decodePkg::opBranch:
                begin
                    pcSrc      = 1'b1;
                    immFmt     = decodePkg::immB;
                    branchType = func3;
                    // 010 and 011 are not assigned to any branch
                    instrBad   = (func3[2:1] == 2'b01);
                end
                decodePkg::opLoad:
                begin
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    aluSrc   = 1'b1;
                    immFmt   = decodePkg::immI;
                end
                decodePkg::opStore:
                begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immFmt   = decodePkg::immS;
                end
                decodePkg::opImm:
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immFmt   = decodePkg::immI;
                    instrBad = functBad;
                end
                decodePkg::opReg:
                begin
                    regWrite = 1'b1;
                    instrBad = functBad;
                end
                decodePkg::opSystem:
                    immFmt = decodePkg::immI;
                default:
                    instrBad = 1'b1;
            endcase
        end
        // Illegal instruction leaves the pipeline as a bubble
        if (instrBad)
        begin
            regWrite   = 1'b0;
            memRead    = 1'b0;
            memWrite   = 1'b0;
            memToReg   = 1'b0;
            aluSrc     = 1'b0;
            pcSrc      = 1'b0;
            immFmt     = decodePkg::immNone;
            branchType = 3'b000;
        end
        illegal = instrBad;
    end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             instValid,
    input  wire decodePkg::instrT instruction,
    input  wire decodePkg::wordT  regValue1,
    input  wire decodePkg::wordT  regValue2,
    output decodePkg::regIdxT     rs1,
    output decodePkg::regIdxT     rs2,
    output decodePkg::regIdxT     rd,
    output logic [2:0]            func3,
    output decodePkg::wordT       imm,
    output decodePkg::wordT       value1,
    output decodePkg::wordT       value2,
    output decodePkg::aluCtrlT    aluControl,
    output logic                  regWrite,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  aluSrc,
    output logic                  pcSrc,
    output logic                  illegal,
    output logic [2:0]            branchType
);

    logic                 validQ;
    decodePkg::instrT     instrQ;
    decodePkg::opcodeT    opcode;
    logic [6:0]           func7;
    decodePkg::immFmtT    immFmt;
    decodePkg::aluModeT   aluMode;
    decodePkg::aluCtrlT   aluCtrlRaw;
    logic                 functBad;

    decodeRegs decodeRegs_i (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instruction (instruction),
        .regValue1   (regValue1),
        .regValue2   (regValue2),
        .validQ      (validQ),
        .instrQ      (instrQ),
        .value1      (value1),
        .value2      (value2)
    );

    // Instruction fields
    assign opcode = instrQ[6:0];
    assign rd     = instrQ[11:7];
    assign func3  = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];
    assign func7  = instrQ[31:25];

    controlDecode controlDecode_i (
        .validQ     (validQ),
        .opcode     (opcode),
        .func3      (func3),
        .functBad   (functBad),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .aluSrc     (aluSrc),
        .pcSrc      (pcSrc),
        .immFmt     (immFmt),
        .aluMode    (aluMode),
        .branchType (branchType),
        .illegal    (illegal)
    );

    aluControlDecode aluControlDecode_i (
        .aluMode    (aluMode),
        .func3      (func3),
        .func7      (func7),
        .aluControl (aluCtrlRaw),
        .functBad   (functBad)
    );

    // ALU code reads zero in a bubble cycle
    assign aluControl = validQ ? aluCtrlRaw : '0;

    immGen immGen_i (
        .instrQ (instrQ),
        .immFmt (immFmt),
        .imm    (imm)
    );

endmodule

`default_nettype wire

// File: tests/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int periodNs = 4
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tests/decodeStage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageSva (
    input wire logic clk,
    input wire logic rst,
    input wire logic instValid,
    input wire logic regWrite,
    input wire logic memRead,
    input wire logic memWrite,
    input wire logic memToReg,
    input wire logic aluSrc,
    input wire logic pcSrc,
    input wire logic illegal
);

    logic anyControl;
    int   assertFails = 0;

    assign anyControl = regWrite | memRead | memWrite | memToReg | aluSrc | pcSrc;

    // A memory access is either a load or a store
    memExclusive: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
        else
        begin
            $error("memRead and memWrite are high in the same cycle");
            assertFails++;
        end

    illegalQuiet: assert property (@(posedge clk) disable iff (rst) illegal |-> !anyControl)
        else
        begin
            $error("Control raised together with illegal");
            assertFails++;
        end

    // Bubble in, bubble out one cycle later
    bubbleQuiet: assert property (@(posedge clk) disable iff (rst)
        !instValid |=> !(anyControl || illegal))
        else
        begin
            $error("Control or illegal raised after an invalid slot");
            assertFails++;
        end

endmodule

bind decodeStage decodeStageSva decodeStageSva_i (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .regWrite  (regWrite),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .memToReg  (memToReg),
    .aluSrc    (aluSrc),
    .pcSrc     (pcSrc),
    .illegal   (illegal)
);

`default_nettype wire

// File: tests/tb_decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decodeStage;

    localparam int    clkPeriod = 4;
    localparam int    maxTests  = 64;
    localparam string tracePath = "tests/decode_trace.txt";

    logic               clk;
    logic               rst;
    logic               instValid;
    decodePkg::instrT   instruction;
    decodePkg::wordT    regValue1;
    decodePkg::wordT    regValue2;

    decodePkg::regIdxT  rs1;
    decodePkg::regIdxT  rs2;
    decodePkg::regIdxT  rd;
    logic [2:0]         func3;
    decodePkg::wordT    imm;
    decodePkg::wordT    value1;
    decodePkg::wordT    value2;
    decodePkg::aluCtrlT aluControl;
    logic               regWrite;
    logic               memRead;
    logic               memWrite;
    logic               memToReg;
    logic               aluSrc;
    logic               pcSrc;
    logic               illegal;
    logic [2:0]         branchType;
    logic [6:0]         controls;

    // Trace contents per test
    string       testName [maxTests];
    logic        validTr  [maxTests];
    logic [31:0] instrTr  [maxTests];
    logic [31:0] op1Tr    [maxTests];
    logic [31:0] op2Tr    [maxTests];
    logic [31:0] immTr    [maxTests];
    logic [4:0]  aluTr    [maxTests];
    logic [6:0]  ctrlTr   [maxTests];
    logic [2:0]  branchTr [maxTests];

    integer seed;
    int     numTests;
    int     passCount;
    int     failCount;
    bit     testBad;
    bit     loadOk;
    int     idx;

    assign controls = {regWrite, memRead, memWrite, memToReg, aluSrc, pcSrc, illegal};

    tbClock #(.periodNs(clkPeriod)) tbClock_i (.clk(clk));

    decodeStage decodeStage_i (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instruction (instruction),
        .regValue1   (regValue1),
        .regValue2   (regValue2),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .func3       (func3),
        .imm         (imm),
        .value1      (value1),
        .value2      (value2),
        .aluControl  (aluControl),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .aluSrc      (aluSrc),
        .pcSrc       (pcSrc),
        .illegal     (illegal),
        .branchType  (branchType)
    );

    task automatic loadTrace();
        int          fd;
        int          count;
        string       lineStr;
        string       nameStr;
        logic [31:0] validVal;
        logic [31:0] instrVal;
        logic [31:0] rndVal;
        logic [31:0] op1Val;
        logic [31:0] op2Val;
        logic [31:0] immVal;
        logic [31:0] aluVal;
        logic [6:0]  ctrlVal;
        logic [31:0] brVal;
        loadOk = 1'b0;
        numTests = 0;
        fd = $fopen(tracePath, "r");
        if (fd == 0)
            return;
        while (!$feof(fd))
        begin
            lineStr = "";
            if ($fgets(lineStr, fd) == 0)
                break;
            if (lineStr.len() < 2 || lineStr[0] == "#")
                continue;
            count = $sscanf(lineStr, "%s %h %h %h %h %h %h %h %b %h", nameStr, validVal,
                            instrVal, rndVal, op1Val, op2Val, immVal, aluVal, ctrlVal, brVal);
            if (count != 10 || numTests == maxTests)
            begin
                $display("Trace line could not be parsed: %0s", lineStr);
                $fclose(fd);
                return;
            end
            testName[numTests] = nameStr;
            validTr[numTests]  = validVal[0];
            instrTr[numTests]  = instrVal;
            immTr[numTests]    = immVal;
            aluTr[numTests]    = aluVal[4:0];
            ctrlTr[numTests]   = ctrlVal;
            branchTr[numTests] = brVal[2:0];
            // Random operands are expected back unchanged
            if (rndVal != 0)
            begin
                op1Tr[numTests] = $random(seed);
                op2Tr[numTests] = $random(seed);
            end
            else
            begin
                op1Tr[numTests] = op1Val;
                op2Tr[numTests] = op2Val;
            end
            numTests++;
        end
        $fclose(fd);
        loadOk = (numTests > 0);
    endtask

    task automatic driveLine(input int n);
        instValid   <= validTr[n];
        instruction <= instrTr[n];
        regValue1   <= op1Tr[n];
        regValue2   <= op2Tr[n];
    endtask

    task automatic checkField(input string name, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            $display("Mismatch %0s %0s: expected %h, actual %h", name, field, expected, actual);
            testBad = 1'b1;
        end
    endtask

    task automatic reportTest(input string name);
        if (testBad)
        begin
            failCount++;
            $display("FAIL %0s", name);
        end
        else
        begin
            passCount++;
            $display("PASS %0s", name);
        end
        testBad = 1'b0;
    endtask

    task automatic checkReset();
        checkField("reset", "controls", 32'h0, controls);
        checkField("reset", "imm", 32'h0, imm);
        checkField("reset", "aluControl", 32'h0, aluControl);
        checkField("reset", "branchType", 32'h0, branchType);
        checkField("reset", "value1", 32'h0, value1);
        checkField("reset", "value2", 32'h0, value2);
        reportTest("reset");
    endtask

    task automatic checkLine(input int n);
        checkField(testName[n], "value1", op1Tr[n], value1);
        checkField(testName[n], "value2", op2Tr[n], value2);
        checkField(testName[n], "imm", immTr[n], imm);
        checkField(testName[n], "aluControl", aluTr[n], aluControl);
        checkField(testName[n], "controls", ctrlTr[n], controls);
        checkField(testName[n], "branchType", branchTr[n], branchType);
        // Register fields by the RISC-V encoding
        checkField(testName[n], "rd", instrTr[n][11:7], rd);
        checkField(testName[n], "func3", instrTr[n][14:12], func3);
        checkField(testName[n], "rs1", instrTr[n][19:15], rs1);
        checkField(testName[n], "rs2", instrTr[n][24:20], rs2);
        reportTest(testName[n]);
    endtask

    // Watchdog sized from the trace length
    initial
    begin
        wait (loadOk);
        #((numTests + 10) * clkPeriod);
        $display("Timeout: the trace did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        seed        = 32'h965e52cc;
        rst         = 1'b1;
        // Live load on the inputs while reset holds the registers
        instValid   = 1'b1;
        instruction = 32'hffc12183;
        regValue1   = 32'h5a5a5a5a;
        regValue2   = 32'ha5a5a5a5;
        passCount   = 0;
        failCount   = 0;
        testBad     = 1'b0;
        loadTrace();
        if (!loadOk)
        begin
            $display("The trace file could not be read");
            $display("Simulation failed");
            $finish;
        end
        else
        begin
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            checkReset();
            @(posedge clk);
            driveLine(0);
            // Next line goes in while the previous one is checked
            for (idx = 0; idx < numTests; idx++)
            begin
                @(posedge clk);
                if (idx + 1 < numTests)
                    driveLine(idx + 1);
                else
                    instValid <= 1'b0;
                @(negedge clk);
                checkLine(idx);
            end
            $display("Tests: %0d run, %0d passed, %0d failed, %0d assertion failures",
                     passCount + failCount, passCount, failCount,
                     decodeStage_i.decodeStageSva_i.assertFails);
            if (failCount == 0 && decodeStage_i.decodeStageSva_i.assertFails == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/decode_trace.txt
# name valid instruction rnd op1 op2 | expected: imm aluControl controls branchType
# controls bits: regWrite memRead memWrite memToReg aluSrc pcSrc illegal; rnd 1 = random operands
bubbleStart 0 00000013 0 0000000a 00000014 00000000 00 0000000 0
lui         1 abcde2b7 0 11111111 22222222 abcde000 02 1000100 0
auipc       1 00012097 0 33333333 44444444 00012000 02 1000100 0
jalBack     1 ff9ff0ef 0 55555555 66666666 fffffff8 02 1000110 0
jalr        1 01008067 0 77777777 88888888 00000010 02 1000110 0
lwNeg       1 ffc12183 0 99999999 aaaaaaaa fffffffc 02 1101100 0
sw          1 00512423 0 bbbbbbbb cccccccc 00000008 02 0010100 0
sbNeg       1 fe638fa3 0 dddddddd eeeeeeee ffffffff 02 0010100 0
beqBack     1 fe2088e3 0 12345678 9abcdef0 fffffff0 04 0000010 0
bne         1 00419463 0 0fedcba9 87654321 00000008 04 0000010 1
bge         1 0000d263 0 80000000 7fffffff 00000004 04 0000010 5
bltu        1 0062e0e3 0 00000001 fffffffe 00000800 04 0000010 6
csrrw       1 30511073 0 deadbeef cafef00d 00000305 02 0000000 0
addiNeg     1 fff00093 1 00000000 00000000 ffffffff 02 1000100 0
slti        1 0050a113 1 00000000 00000000 00000005 09 1000100 0
sltiu       1 0050b113 1 00000000 00000000 00000005 0a 1000100 0
xori        1 0ff0c113 1 00000000 00000000 000000ff 03 1000100 0
ori         1 0ff0e113 1 00000000 00000000 000000ff 01 1000100 0
andi        1 0ff0f113 1 00000000 00000000 000000ff 00 1000100 0
slli        1 00309113 1 00000000 00000000 00000003 06 1000100 0
srli        1 0030d113 1 00000000 00000000 00000003 07 1000100 0
srai        1 4030d113 1 00000000 00000000 00000403 08 1000100 0
bubbleMid   0 002081b3 1 00000000 00000000 00000000 00 0000000 0
add         1 002081b3 1 00000000 00000000 00000000 02 1000000 0
sub         1 402081b3 1 00000000 00000000 00000000 04 1000000 0
sll         1 002091b3 1 00000000 00000000 00000000 06 1000000 0
slt         1 0020a1b3 1 00000000 00000000 00000000 09 1000000 0
sltu        1 0020b1b3 1 00000000 00000000 00000000 0a 1000000 0
xor         1 0020c1b3 1 00000000 00000000 00000000 03 1000000 0
srl         1 0020d1b3 1 00000000 00000000 00000000 07 1000000 0
sra         1 4020d1b3 1 00000000 00000000 00000000 08 1000000 0
or          1 0020e1b3 1 00000000 00000000 00000000 01 1000000 0
and         1 0020f1b3 1 00000000 00000000 00000000 00 1000000 0
mul         1 022081b3 1 00000000 00000000 00000000 0b 1000000 0
mulh        1 022091b3 1 00000000 00000000 00000000 0c 1000000 0
mulhsu      1 0220a1b3 1 00000000 00000000 00000000 0d 1000000 0
mulhu       1 0220b1b3 1 00000000 00000000 00000000 0e 1000000 0
div         1 0220c1b3 1 00000000 00000000 00000000 0f 1000000 0
divu        1 0220d1b3 1 00000000 00000000 00000000 10 1000000 0
rem         1 0220e1b3 1 00000000 00000000 00000000 11 1000000 0
remu        1 0220f1b3 1 00000000 00000000 00000000 12 1000000 0
badOpcode   1 0000007f 0 01010101 02020202 00000000 02 0000001 0
badFunc7    1 202081b3 0 03030303 04040404 00000000 02 0000001 0
badSlli     1 40309113 0 05050505 06060606 00000000 02 0000001 0
jalrBadF3   1 01009067 0 07070707 08080808 00000000 02 0000001 0
beqF3010    1 fe20a8e3 0 09090909 0a0a0a0a 00000000 04 0000001 0
bubbleEnd   0 00000000 0 00000000 00000000 00000000 00 0000000 0

// File: sources.f
rtl/decodePkg.sv
rtl/decodeRegs.sv
rtl/immGen.sv
rtl/aluControlDecode.sv
rtl/controlDecode.sv
rtl/decodeStage.sv
tests/tbClock.sv
tests/decodeStage_sva.sv
tests/tb_decodeStage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - rtl/decodePkg.sv
      - rtl/decodeRegs.sv
      - rtl/immGen.sv
      - rtl/aluControlDecode.sv
      - rtl/controlDecode.sv
      - rtl/decodeStage.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/decodeStage_sva.sv
      - tests/tb_decodeStage.sv
